/* source/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

   //////////////////////////////////////////////////
   // core vector types

   typedef logic [7:0]  byte_t;
   typedef logic [8:0]  code_addr_t;
   typedef logic [15:0] dptr_t;
   typedef logic [2:0]  reg_idx_t;

   localparam int unsigned code_depth       = 512;      // bytes loaded after reset
   localparam code_addr_t  reset_pc         = 9'd0;
   localparam dptr_t       tx_port_addr     = 16'h0201; // movx write sends a byte
   localparam dptr_t       status_port_addr = 16'h0200; // movx read gives tx busy

   //////////////////////////////////////////////////
   // opcodes, full byte

   localparam byte_t op_ljmp        = 8'h02;
   localparam byte_t op_dec_a       = 8'h14;
   localparam byte_t op_add_a_imm   = 8'h24;
   localparam byte_t op_rlc         = 8'h33;
   localparam byte_t op_jc          = 8'h40;
   localparam byte_t op_jnc         = 8'h50;
   localparam byte_t op_jz          = 8'h60;
   localparam byte_t op_xrl_a_imm   = 8'h64;
   localparam byte_t op_mov_a_imm   = 8'h74;
   localparam byte_t op_sjmp        = 8'h80;
   localparam byte_t op_mov_dptr    = 8'h90;
   localparam byte_t op_subb_a_imm  = 8'h94;
   localparam byte_t op_clr_c       = 8'hc3;
   localparam byte_t op_movx_a_dptr = 8'he0;
   localparam byte_t op_clr_a       = 8'he4;
   localparam byte_t op_movx_dptr_a = 8'hf0;
   localparam byte_t op_cpl_a       = 8'hf4;

   // register forms, compared against opcode[7:3]
   localparam logic [4:0] op_inc_r     = 5'h01; // 08..0f
   localparam logic [4:0] op_dec_r     = 5'h03; // 18..1f
   localparam logic [4:0] op_add_a_r   = 5'h05; // 28..2f
   localparam logic [4:0] op_mov_r_imm = 5'h0f; // 78..7f
   localparam logic [4:0] op_subb_a_r  = 5'h13; // 98..9f
   localparam logic [4:0] op_mov_a_r   = 5'h1d; // e8..ef
   localparam logic [4:0] op_mov_r_a   = 5'h1f; // f8..ff

   typedef enum logic [2:0] {
      fetch,
      decode0,
      decode1,
      decode2,
      execute
   } seq_state_t;

endpackage

`default_nettype wire

/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

   localparam int unsigned sample_cycles = 104;  // clocks per bit

   typedef logic [$clog2(sample_cycles)-1:0] sample_cnt_t;

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_send
   } tx_state_t;

endpackage

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire             i_clk,
   input  wire             i_nrst,
   input  wire             i_rx,
   output mcu_pkg::byte_t  o_byte,
   output logic            o_byte_valid
);
   import mcu_pkg::*;
   import uart_pkg::*;

   localparam sample_cnt_t half_cnt = sample_cnt_t'(sample_cycles / 2 - 1);
   localparam sample_cnt_t last_cnt = sample_cnt_t'(sample_cycles - 1);

   logic        rx_meta;
   logic        rx_s;
   rx_state_t   state;
   sample_cnt_t cnt;
   byte_t       shift;

   // two flop synchronizer, idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_s    <= rx_meta;
      end
   end

   //////////////////////////////////////////////////
   // frame fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state        <= rx_idle;
         cnt          <= '0;
         o_byte_valid <= 1'b0;
      end else begin
         o_byte_valid <= 1'b0;
         cnt          <= cnt + 1'b1;
         case (state)
            rx_idle: begin
               cnt <= '0;
               if (!rx_s) state <= rx_start;   // falling edge of start bit
            end
            rx_start: if (cnt == half_cnt) begin
               cnt   <= '0;
               // glitch shorter than half a bit goes back to idle
               state <= rx_s ? rx_idle : rx_data;
            end
            rx_data: if (cnt == last_cnt) begin
               cnt <= '0;
               if (shift[0]) state <= rx_stop;  // marker reached bit 0
            end
            rx_stop: if (cnt == last_cnt) begin
               o_byte_valid <= 1'b1;            // middle of stop bit
               state        <= rx_idle;
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // lsb first, marker bit ends the word
   always_ff @(posedge i_clk) begin
      if (state == rx_start && cnt == half_cnt) begin
         shift <= 8'h80;
      end else if (state == rx_data && cnt == last_cnt) begin
         shift <= {rx_s, shift[7:1]};
      end
   end

   assign o_byte = shift;

endmodule

`default_nettype wire

/* source/code_store.sv */
`timescale 1ns/1ps
`default_nettype none

module code_store (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire mcu_pkg::byte_t i_wr_data,
   input  wire                 i_wr_valid,
   input  wire mcu_pkg::code_addr_t i_rd_addr,
   output mcu_pkg::byte_t      o_rd_data,
   output logic                o_load_done
);
   import mcu_pkg::*;

   byte_t      mem [code_depth];
   code_addr_t load_cnt;
   logic       wr_en;

   // bytes after the last one are ignored
   assign wr_en = i_wr_valid && !o_load_done;

   //////////////////////////////////////////////////
   // memory, one cycle read

   always_ff @(posedge i_clk) begin
      if (wr_en) mem[load_cnt] <= i_wr_data;
      o_rd_data <= mem[i_rd_addr];
   end

   //////////////////////////////////////////////////
   // loader

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_cnt    <= '0;
         o_load_done <= 1'b0;
      end else if (wr_en) begin
         load_cnt <= load_cnt + 1'b1;
         // counter wraps on the last byte
         if (load_cnt == code_addr_t'(code_depth - 1)) o_load_done <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* source/cpu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire                  i_load_done,
   input  wire mcu_pkg::byte_t  i_code_data,
   input  wire                  i_acc_zero,
   input  wire                  i_carry,
   output mcu_pkg::code_addr_t  o_code_addr,
   output mcu_pkg::byte_t       o_op,
   output mcu_pkg::byte_t       o_opnd1,
   output mcu_pkg::byte_t       o_opnd2,
   output logic                 o_execute
);
   import mcu_pkg::*;

   seq_state_t state;
   seq_state_t state_next;
   code_addr_t pc;
   code_addr_t pc_next;
   code_addr_t rel_target;
   byte_t      op_q;
   byte_t      opnd1_q;
   byte_t      opnd2_q;
   byte_t      cur_op;
   logic       len2;
   logic       len3;
   logic       pc_inc;
   logic       taken;

   // opcode is live on the code bus during decode0
   assign cur_op = (state == decode0) ? i_code_data : op_q;

   //////////////////////////////////////////////////
   // length class

   always_comb begin
      len2 = 1'b0;
      len3 = 1'b0;
      case (cur_op)
         op_mov_a_imm, op_add_a_imm, op_subb_a_imm, op_xrl_a_imm,
         op_sjmp, op_jc, op_jnc, op_jz: len2 = 1'b1;
         op_ljmp, op_mov_dptr:          len3 = 1'b1;
         default:                       len2 = (cur_op[7:3] == op_mov_r_imm);
      endcase
   end

   always_comb begin
      state_next = state;
      case (state)
         fetch:   if (i_load_done) state_next = decode0;
         decode0: state_next = (len2 || len3) ? decode1 : execute;
         decode1: state_next = len3 ? decode2 : execute;
         decode2: state_next = execute;
         execute: state_next = fetch;
         default: state_next = fetch;
      endcase
   end

   //////////////////////////////////////////////////
   // program counter

   // pc points past the instruction once decode is over
   assign pc_inc = (state == fetch && i_load_done) ||
                   (state == decode0 && (len2 || len3)) ||
                   (state == decode1 && len3);

   assign taken = (op_q == op_sjmp) ||
                  (op_q == op_jc  &&  i_carry) ||
                  (op_q == op_jnc && !i_carry) ||
                  (op_q == op_jz  &&  i_acc_zero);

   assign rel_target = pc + code_addr_t'({opnd1_q[7], opnd1_q});  // signed offset

   always_comb begin
      pc_next = pc;
      if (state == execute && op_q == op_ljmp) begin
         pc_next = code_addr_t'({opnd1_q, opnd2_q});
      end else if (state == execute && taken) begin
         pc_next = rel_target;
      end else if (pc_inc) begin
         pc_next = pc + 1'b1;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= fetch;
         pc    <= reset_pc;
      end else begin
         state <= state_next;
         pc    <= pc_next;
      end
   end

   // instruction bytes
   always_ff @(posedge i_clk) begin
      if (state == decode0) op_q    <= i_code_data;
      if (state == decode1) opnd1_q <= i_code_data;  // imm, offset or high byte
      if (state == decode2) opnd2_q <= i_code_data;  // low byte
   end

   assign o_code_addr = pc;
   assign o_op        = op_q;
   assign o_opnd1     = opnd1_q;
   assign o_opnd2     = opnd2_q;
   assign o_execute   = (state == execute);

endmodule

`default_nettype wire

/* source/cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_execute,
   input  wire mcu_pkg::byte_t i_op,
   input  wire mcu_pkg::byte_t i_opnd1,
   input  wire mcu_pkg::byte_t i_opnd2,
   input  wire                 i_tx_busy,
   output logic                o_acc_zero,
   output logic                o_carry,
   output logic                o_port_wr,
   output mcu_pkg::byte_t      o_port_data
);
   import mcu_pkg::*;

   byte_t      acc;
   byte_t      acc_next;
   logic       carry;
   logic       carry_next;
   dptr_t      dptr;
   dptr_t      dptr_next;
   byte_t      regs [8];
   reg_idx_t   r_idx;
   byte_t      r_sel;
   byte_t      r_next;
   logic       r_upd;
   logic [4:0] op5;
   logic       alu_sub;
   byte_t      alu_b;
   logic [8:0] alu_sum;
   byte_t      rd_data;

   assign op5   = i_op[7:3];
   assign r_idx = reg_idx_t'(i_op[2:0]);
   assign r_sel = regs[r_idx];

   //////////////////////////////////////////////////
   // add/subb, one carry chain

   // subb runs as acc + ~b + ~c, borrow is the inverted carry out
   assign alu_sub = (i_op == op_subb_a_imm) || (op5 == op_subb_a_r);
   assign alu_b   = (op5 == op_add_a_r || op5 == op_subb_a_r) ? r_sel : i_opnd1;
   assign alu_sum = {1'b0, acc} + {1'b0, alu_sub ? ~alu_b : alu_b} +
                    {8'd0, alu_sub & ~carry};

   // movx read, only the status port answers
   assign rd_data = (dptr == status_port_addr) ? {7'd0, i_tx_busy} : 8'h00;

   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      dptr_next  = dptr;
      r_next     = r_sel;
      r_upd      = 1'b0;
      case (i_op)
         op_mov_a_imm:   acc_next = i_opnd1;
         op_add_a_imm, op_subb_a_imm: begin
            acc_next   = alu_sum[7:0];
            carry_next = alu_sum[8] ^ alu_sub;
         end
         op_xrl_a_imm:   acc_next = acc ^ i_opnd1;
         op_clr_a:       acc_next = 8'h00;
         op_cpl_a:       acc_next = ~acc;
         op_dec_a:       acc_next = acc - 8'd1;
         op_rlc: begin
            acc_next   = {acc[6:0], carry};  // through carry
            carry_next = acc[7];
         end
         op_clr_c:       carry_next = 1'b0;
         op_mov_dptr:    dptr_next  = {i_opnd1, i_opnd2};
         op_movx_a_dptr: acc_next   = rd_data;
         default: begin
            r_upd = (op5 == op_mov_r_imm) || (op5 == op_mov_r_a) ||
                    (op5 == op_inc_r) || (op5 == op_dec_r);
            case (op5)
               op_mov_r_imm: r_next   = i_opnd1;
               op_mov_r_a:   r_next   = acc;
               op_inc_r:     r_next   = r_sel + 8'd1;
               op_dec_r:     r_next   = r_sel - 8'd1;
               op_mov_a_r:   acc_next = r_sel;
               op_add_a_r, op_subb_a_r: begin
                  acc_next   = alu_sum[7:0];
                  carry_next = alu_sum[8] ^ alu_sub;
               end
               default: r_next = r_sel;  // nop and unknown opcodes
            endcase
         end
      endcase
   end

   //////////////////////////////////////////////////
   // state registers

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (i_execute) begin
         acc   <= acc_next;
         carry <= carry_next;
         dptr  <= dptr_next;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_execute && r_upd) regs[r_idx] <= r_next;
   end

   assign o_acc_zero  = (acc == 8'h00);
   assign o_carry     = carry;
   assign o_port_wr   = i_execute && (i_op == op_movx_dptr_a) && (dptr == tx_port_addr);
   assign o_port_data = acc;

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_wr,
   input  wire mcu_pkg::byte_t i_data,
   output logic                o_tx,
   output logic                o_busy
);
   import mcu_pkg::*;
   import uart_pkg::*;

   tx_state_t   state;
   sample_cnt_t cnt;
   logic [3:0]  bit_cnt;
   byte_t       shift;
   logic        bit_end;

   assign bit_end = (cnt == sample_cnt_t'(sample_cycles - 1));

   //////////////////////////////////////////////////
   // frame fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= tx_idle;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         if (state == tx_idle || bit_end) cnt <= '0;
         else                             cnt <= cnt + 1'b1;
         case (state)
            tx_idle: begin
               bit_cnt <= '0;
               if (i_wr) state <= tx_start;  // writes while busy are lost
            end
            tx_start: if (bit_end) state <= tx_send;
            tx_send: if (bit_end) begin
               bit_cnt <= bit_cnt + 1'b1;
               // 8 data bits then the stop bit
               if (bit_cnt == 4'd8) state <= tx_idle;
            end
            default: state <= tx_idle;
         endcase
      end
   end

   // msb first, ones fill in behind for the stop bit
   always_ff @(posedge i_clk) begin
      if (state == tx_idle && i_wr) begin
         shift <= i_data;
      end else if (state == tx_send && bit_end) begin
         shift <= {shift[6:0], 1'b1};
      end
   end

   assign o_tx   = (state == tx_idle)  ? 1'b1 :
                   (state == tx_start) ? 1'b0 :
                                         shift[7];
   assign o_busy = (state != tx_idle);

endmodule

`default_nettype wire

/* source/mcu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_top (
   input  wire i_clk,
   input  wire i_nrst,
   input  wire i_uart_rx,
   output wire o_uart_tx
);
   import mcu_pkg::*;

   byte_t      rx_byte;
   logic       rx_valid;
   logic       load_done;
   code_addr_t code_addr;
   byte_t      code_data;
   byte_t      op;
   byte_t      opnd1;
   byte_t      opnd2;
   logic       exec_strobe;
   logic       acc_zero;
   logic       carry;
   logic       port_wr;
   byte_t      port_data;
   logic       tx_busy;

   //////////////////////////////////////////////////
   // program load path

   uart_rx u_uart_rx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx         (i_uart_rx),
      .o_byte       (rx_byte),
      .o_byte_valid (rx_valid)
   );

   code_store u_code_store (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_wr_data   (rx_byte),
      .i_wr_valid  (rx_valid),
      .i_rd_addr   (code_addr),
      .o_rd_data   (code_data),
      .o_load_done (load_done)
   );

   //////////////////////////////////////////////////
   // core and output port

   cpu_sequencer u_cpu_sequencer (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (code_data),
      .i_acc_zero  (acc_zero),
      .i_carry     (carry),
      .o_code_addr (code_addr),
      .o_op        (op),
      .o_opnd1     (opnd1),
      .o_opnd2     (opnd2),
      .o_execute   (exec_strobe)
   );

   cpu_datapath u_cpu_datapath (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_execute   (exec_strobe),
      .i_op        (op),
      .i_opnd1     (opnd1),
      .i_opnd2     (opnd2),
      .i_tx_busy   (tx_busy),
      .o_acc_zero  (acc_zero),
      .o_carry     (carry),
      .o_port_wr   (port_wr),
      .o_port_data (port_data)
   );

   uart_tx u_uart_tx (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_wr   (port_wr),
      .i_data (port_data),
      .o_tx   (o_uart_tx),
      .o_busy (tx_busy)
   );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic o_clk,
   output logic o_nrst
);

   // 8 ns period
   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

   initial begin
      o_nrst = 1'b0;
      repeat (10) @(posedge o_clk);
      #1 o_nrst = 1'b1;  // released off the edge
   end

endmodule

`default_nettype wire

/* sim/tb_mcu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mcu;
   import mcu_pkg::*;
   import uart_pkg::*;

   localparam byte_t carry_set_tag   = 8'hc1;
   localparam byte_t carry_clear_tag = 8'h0c;
   localparam byte_t marker          = 8'hee;  // must never go out
   localparam int    bit_cycles      = sample_cycles;
   localparam int    half_bit        = sample_cycles / 2;
   localparam int    reset_timeout   = 100;
   localparam int    frames_timeout  = 100000;

   logic   clk;
   logic   nrst;
   logic   uart_rx;
   wire    uart_tx;

   integer seed;
   byte_t  prog [code_depth];
   int     asm_pc;
   byte_t  model_acc;
   logic   model_carry;
   byte_t  model_regs [8];
   byte_t  expected_q [$];
   logic   load_phase;
   logic   mon_active;
   int     mon_cnt;
   int     mon_slot;
   byte_t  mon_shift;

   tb_clock u_clock (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   mcu_top DUT (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   //////////////////////////////////////////////////
   // failure reporting

   task automatic abort_test(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input byte_t got, input byte_t exp);
      abort_test($sformatf("Error at %0t ns: %s = 0x%02h, expected 0x%02h",
                           $time, name, got, exp));
   endtask

   //////////////////////////////////////////////////
   // program assembler with a model of the core

   task automatic next_random(output byte_t value);
      integer raw;
      raw   = $random(seed);
      value = raw[7:0];
   endtask

   task automatic emit_byte(input byte_t b);
      if (asm_pc >= int'(code_depth)) begin
         abort_test("test program does not fit in code memory");
      end else begin
         prog[asm_pc] = b;
         asm_pc       = asm_pc + 1;
      end
   endtask

   task automatic apply_add(input byte_t value);
      logic [8:0] sum;
      sum         = {1'b0, model_acc} + {1'b0, value};
      model_acc   = sum[7:0];
      model_carry = sum[8];
   endtask

   // borrow shows up as bit 8 of the 9 bit difference
   task automatic apply_subb(input byte_t value);
      logic [8:0] diff;
      diff        = {1'b0, model_acc} - {1'b0, value} - {8'd0, model_carry};
      model_acc   = diff[7:0];
      model_carry = diff[8];
   endtask

   task automatic imm_op(input byte_t op, input byte_t value);
      emit_byte(op);
      emit_byte(value);
      case (op)
         op_mov_a_imm:  model_acc = value;
         op_add_a_imm:  apply_add(value);
         op_subb_a_imm: apply_subb(value);
         op_xrl_a_imm:  model_acc = model_acc ^ value;
         default:       abort_test("unsupported immediate instruction in test program");
      endcase
   endtask

   task automatic acc_op(input byte_t op);
      emit_byte(op);
      case (op)
         op_clr_a: model_acc = 8'h00;
         op_cpl_a: model_acc = ~model_acc;
         op_dec_a: model_acc = model_acc - 8'd1;
         op_rlc:   {model_carry, model_acc} = {model_acc, model_carry};  // through carry
         op_clr_c: model_carry = 1'b0;
         default:  abort_test("unsupported accumulator instruction in test program");
      endcase
   endtask

   task automatic set_reg(input reg_idx_t idx, input byte_t value);
      emit_byte({op_mov_r_imm, idx});
      emit_byte(value);
      model_regs[idx] = value;
   endtask

   task automatic reg_op(input logic [4:0] op5, input reg_idx_t idx);
      emit_byte({op5, idx});
      case (op5)
         op_inc_r:    model_regs[idx] = model_regs[idx] + 8'd1;
         op_dec_r:    model_regs[idx] = model_regs[idx] - 8'd1;
         op_mov_a_r:  model_acc = model_regs[idx];
         op_mov_r_a:  model_regs[idx] = model_acc;
         op_add_a_r:  apply_add(model_regs[idx]);
         op_subb_a_r: apply_subb(model_regs[idx]);
         default:     abort_test("unsupported register instruction in test program");
      endcase
   endtask

   task automatic set_dptr(input logic [15:0] addr);
      emit_byte(op_mov_dptr);
      emit_byte(addr[15:8]);
      emit_byte(addr[7:0]);
   endtask

   // park A in R7 and poll the status port before writing A to the tx port
   task automatic transmit_acc();
      int poll_at;
      reg_op(op_mov_r_a, 3'd7);
      set_dptr(status_port_addr);
      poll_at = asm_pc;
      emit_byte(op_movx_a_dptr);
      emit_byte(op_jz);
      emit_byte(8'h02);  // over the sjmp once idle
      emit_byte(op_sjmp);
      emit_byte(byte_t'(poll_at - (asm_pc + 1)));
      reg_op(op_mov_a_r, 3'd7);
      set_dptr(tx_port_addr);
      emit_byte(op_movx_dptr_a);
      expected_q.push_back(model_acc);
   endtask

   // sends a tag picked by JC or JNC while A waits in R6
   task automatic report_carry(input logic use_jnc);
      reg_op(op_mov_r_a, 3'd6);
      emit_byte(use_jnc ? op_jnc : op_jc);
      emit_byte(8'h04);
      emit_byte(op_mov_a_imm);
      emit_byte(use_jnc ? carry_set_tag : carry_clear_tag);
      emit_byte(op_sjmp);
      emit_byte(8'h02);
      emit_byte(op_mov_a_imm);
      emit_byte(use_jnc ? carry_clear_tag : carry_set_tag);
      model_acc = model_carry ? carry_set_tag : carry_clear_tag;
      transmit_acc();
      reg_op(op_mov_a_r, 3'd6);
   endtask

   // jumped over code leaves the model untouched
   task automatic skipped_marker();
      byte_t saved_acc;
      byte_t saved_r7;
      saved_acc = model_acc;
      saved_r7  = model_regs[7];
      imm_op(op_mov_a_imm, marker);
      transmit_acc();
      expected_q.delete(expected_q.size() - 1);
      model_acc     = saved_acc;
      model_regs[7] = saved_r7;
   endtask

   task automatic build_program();
      byte_t       value;
      int          k;
      int          at;
      logic [15:0] target;
      for (k = 0; k < int'(code_depth); k++) begin
         prog[k] = 8'h00;  // nop padding
      end
      asm_pc      = 0;
      model_acc   = 8'h00;
      model_carry = 1'b0;

      // one byte out while the transmitter is idle
      set_dptr(tx_port_addr);
      next_random(value);
      imm_op(op_mov_a_imm, value);
      emit_byte(op_movx_dptr_a);
      expected_q.push_back(model_acc);

      // arithmetic on random values
      next_random(value);
      imm_op(op_mov_a_imm, value);
      acc_op(op_clr_c);
      next_random(value);
      imm_op(op_add_a_imm, value);
      transmit_acc();
      report_carry(1'b0);
      next_random(value);
      imm_op(op_subb_a_imm, value);
      transmit_acc();
      report_carry(1'b1);
      next_random(value);
      imm_op(op_xrl_a_imm, value);
      transmit_acc();
      acc_op(op_cpl_a);
      transmit_acc();
      acc_op(op_rlc);
      transmit_acc();
      report_carry(1'b0);

      // both carry values through both branches
      acc_op(op_clr_c);
      report_carry(1'b0);
      report_carry(1'b1);
      imm_op(op_mov_a_imm, 8'hf0);
      imm_op(op_add_a_imm, 8'h20);
      transmit_acc();
      report_carry(1'b0);
      report_carry(1'b1);
      imm_op(op_subb_a_imm, 8'h05);  // borrow in
      transmit_acc();

      // register bank
      for (k = 0; k < 4; k++) begin
         next_random(value);
         set_reg(reg_idx_t'(k), value);
      end
      reg_op(op_inc_r, 3'd0);
      reg_op(op_dec_r, 3'd1);
      reg_op(op_inc_r, 3'd3);
      reg_op(op_mov_a_r, 3'd0);
      transmit_acc();
      reg_op(op_add_a_r, 3'd1);
      transmit_acc();
      reg_op(op_mov_a_r, 3'd2);
      acc_op(op_clr_c);
      reg_op(op_subb_a_r, 3'd3);
      transmit_acc();
      reg_op(op_mov_a_r, 3'd3);
      transmit_acc();
      acc_op(op_clr_a);
      acc_op(op_dec_a);
      reg_op(op_mov_r_a, 3'd4);
      reg_op(op_inc_r, 3'd4);
      reg_op(op_add_a_r, 3'd4);
      transmit_acc();
      reg_op(op_mov_a_r, 3'd4);
      transmit_acc();

      // back to back bytes through the polling loop
      for (k = 0; k < 3; k++) begin
         next_random(value);
         imm_op(op_mov_a_imm, value);
         transmit_acc();
      end

      // ljmp and sjmp over marker code with targets patched afterwards
      at = asm_pc;
      emit_byte(op_ljmp);
      emit_byte(8'h00);
      emit_byte(8'h00);
      skipped_marker();
      target       = 16'(asm_pc);
      prog[at + 1] = target[15:8];
      prog[at + 2] = target[7:0];
      at = asm_pc;
      emit_byte(op_sjmp);
      emit_byte(8'h00);
      skipped_marker();
      prog[at + 1] = byte_t'(asm_pc - (at + 2));

      emit_byte(op_sjmp);
      emit_byte(8'hfe);  // halt
   endtask

   //////////////////////////////////////////////////
   // uart driver and waits

   task automatic drive_bit(input logic b);
      @(posedge clk);
      #1 uart_rx = b;
      repeat (bit_cycles - 1) @(posedge clk);
   endtask

   task automatic send_uart_byte(input byte_t value, input logic last_byte);
      int i;
      drive_bit(1'b0);
      for (i = 0; i < 8; i++) begin
         drive_bit(value[i]);  // lsb first
      end
      if (last_byte) load_phase = 1'b0;  // load completes inside this stop bit
      drive_bit(1'b1);
   endtask

   task automatic wait_for_reset();
      int n;
      n = 0;
      while (nrst !== 1'b1 && n < reset_timeout) begin
         @(posedge clk);
         n = n + 1;
      end
      if (nrst !== 1'b1) abort_test("timeout waiting for reset release");
   endtask

   task automatic wait_for_frames();
      int n;
      n = 0;
      while (expected_q.size() != 0 && n < frames_timeout) begin
         @(posedge clk);
         n = n + 1;
      end
      if (expected_q.size() != 0) begin
         abort_test($sformatf("timeout with %0d frames not received", expected_q.size()));
      end
   endtask

   //////////////////////////////////////////////////
   // monitor on o_uart_tx

   task automatic check_frame(input byte_t got);
      byte_t exp;
      if (expected_q.size() == 0) begin
         abort_test("unexpected extra frame on o_uart_tx");
      end else begin
         exp = expected_q.pop_front();
         assert (got == exp) else value_error("o_uart_tx byte", got, exp);
      end
   endtask

   // sampled mid bit on the falling edge
   always @(negedge clk) begin
      if (!mon_active) begin
         assert (uart_tx === 1'b1 || (uart_tx === 1'b0 && !load_phase))
            else abort_test(load_phase ? "o_uart_tx left idle during the program load"
                                       : "o_uart_tx is unknown");
         if (uart_tx === 1'b0) begin
            mon_active = 1'b1;
            mon_cnt    = 0;
         end
      end else begin
         mon_cnt = mon_cnt + 1;
         assert (!$isunknown(uart_tx)) else abort_test("o_uart_tx is unknown inside a frame");
         if (mon_cnt >= half_bit && (mon_cnt - half_bit) % bit_cycles == 0) begin
            mon_slot = (mon_cnt - half_bit) / bit_cycles;
            if (mon_slot == 0) begin
               assert (uart_tx === 1'b0)
                  else abort_test("start bit on o_uart_tx too short");
            end else if (mon_slot <= 8) begin
               mon_shift = {mon_shift[6:0], uart_tx};  // msb first
            end else begin
               assert (uart_tx === 1'b1)
                  else abort_test("missing stop bit on o_uart_tx, partial frame");
               check_frame(mon_shift);
               mon_active = 1'b0;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      int i;
      uart_rx    = 1'b1;
      load_phase = 1'b1;
      mon_active = 1'b0;
      mon_cnt    = 0;
      mon_slot   = 0;
      mon_shift  = 8'h00;
      seed       = 32'h8a89_898d;
      build_program();
      wait_for_reset();
      repeat (5) @(posedge clk);
      for (i = 0; i < int'(code_depth); i++) begin
         send_uart_byte(prog[i], i == int'(code_depth) - 1);
      end
      wait_for_frames();
      // quiet time so a stray frame would still be caught
      repeat (30 * bit_cycles) @(posedge clk);
      if (!mon_active) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         abort_test("a frame on o_uart_tx is still in progress at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* flist.f */
source/mcu_pkg.sv
source/uart_pkg.sv
source/uart_rx.sv
source/code_store.sv
source/cpu_sequencer.sv
source/cpu_datapath.sv
source/uart_tx.sv
source/mcu_top.sv
sim/tb_clock.sv
sim/tb_mcu.sv

/* Makefile */
# Verilator flow for the mcu testbench

TOP := tb_mcu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module mcu_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
